// ==== common/soc_cfg.svh ====
// Build-time widths and the address map of the reduced SoC.
// Include this wherever a width or a device window is needed.

`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// bus widths
`define SOC_DW 32
`define SOC_AW 32

// 256 words of SRAM
`define SOC_RAM_AW 8

`define SOC_GPIO_W 8

// each mask covers the offset bits inside its window
`define SOC_RAM_BASE  32'h0000_0000
`define SOC_RAM_MASK  32'h0000_03ff
`define SOC_GPIO_BASE 32'h1000_0000
`define SOC_GPIO_MASK 32'h0000_00ff

`endif

// ==== common/tlul_pkg.sv ====
// Bus types shared by the host port, the crossbar and every device.
// Import with tlul_pkg::* in the module header.

`include "soc_cfg.svh"

package tlul_pkg;

  // A channel and D channel opcodes share one encoding space
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    AccessAck      = 3'h2,
    AccessAckData  = 3'h3,
    Get            = 3'h4
  } tl_opcode_e;

  // host to device
  typedef struct packed {
    logic                     a_valid;
    tl_opcode_e               a_opcode;
    logic [`SOC_AW-1:0]       a_address;
    logic [(`SOC_DW/8)-1:0]   a_mask;
    logic [`SOC_DW-1:0]       a_data;
    logic                     d_ready;
  } tl_h2d_t;

  // device to host
  typedef struct packed {
    logic                     d_valid;
    tl_opcode_e               d_opcode;
    logic [`SOC_DW-1:0]       d_data;
    logic                     d_error;
    logic                     a_ready;
  } tl_d2h_t;

endpackage

// ==== common/soc_pkg.sv ====
// SoC level encodings: device select, GPIO register map and crossbar states.
// Import with soc_pkg::* where one of these is decoded.

package soc_pkg;

  // crossbar target
  typedef enum logic [1:0] {
    DevRam  = 2'd0,
    DevGpio = 2'd1,
    DevNone = 2'd2
  } dev_e;

  // word index of each GPIO register, the byte offset is four times the index
  typedef enum logic [2:0] {
    RegOut        = 3'd0,
    RegOe         = 3'd1,
    // read only
    RegIn         = 3'd2,
    // write one to clear
    RegIntrState  = 3'd3,
    RegIntrEnable = 3'd4
  } gpio_reg_e;

  typedef enum logic {
    StIdle    = 1'b0,
    StWaitRsp = 1'b1
  } xbar_state_e;

endpackage

// ==== hw/xbar/xbar_main.sv ====
// Main crossbar with one host port and two devices, one transaction in flight.
// Unmapped requests are answered here with an error response.

`include "soc_cfg.svh"

module xbar_main import tlul_pkg::*, soc_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  input  tl_h2d_t tl_h_i,
  output tl_d2h_t tl_h_o,
  output tl_h2d_t tl_ram_o,
  input  tl_d2h_t tl_ram_i,
  output tl_h2d_t tl_gpio_o,
  input  tl_d2h_t tl_gpio_i
);

  xbar_state_e state_q;
  dev_e        dev_sel;
  dev_e        dev_q;
  logic        dev_ready;
  logic        host_ready;
  logic        a_xfer;
  logic        d_xfer;
  logic        err_valid_q;
  tl_opcode_e  err_opcode_q;
  tl_d2h_t     rsp;

  // address decode
  always_comb begin
    if ((tl_h_i.a_address & ~`SOC_RAM_MASK) == `SOC_RAM_BASE) begin
      dev_sel = DevRam;
    end else if ((tl_h_i.a_address & ~`SOC_GPIO_MASK) == `SOC_GPIO_BASE) begin
      dev_sel = DevGpio;
    end else begin
      dev_sel = DevNone;
    end
  end

  always_comb begin
    case (dev_sel)
      DevRam:  dev_ready = tl_ram_i.a_ready;
      DevGpio: dev_ready = tl_gpio_i.a_ready;
      default: dev_ready = 1'b1;
    endcase
  end

  assign host_ready = (state_q == StIdle) && dev_ready;
  assign a_xfer     = tl_h_i.a_valid && host_ready;

  // requests go only to the decoded device, d_ready only to the one in flight
  always_comb begin
    tl_ram_o          = tl_h_i;
    tl_ram_o.a_valid  = tl_h_i.a_valid && (state_q == StIdle) && (dev_sel == DevRam);
    tl_ram_o.d_ready  = tl_h_i.d_ready && (state_q == StWaitRsp) && (dev_q == DevRam);
    tl_gpio_o         = tl_h_i;
    tl_gpio_o.a_valid = tl_h_i.a_valid && (state_q == StIdle) && (dev_sel == DevGpio);
    tl_gpio_o.d_ready = tl_h_i.d_ready && (state_q == StWaitRsp) && (dev_q == DevGpio);
  end

  // response select
  always_comb begin
    rsp = '{d_valid: 1'b0, d_opcode: AccessAck, d_data: '0, d_error: 1'b0, a_ready: 1'b0};
    if (state_q == StWaitRsp) begin
      case (dev_q)
        DevRam:  rsp = tl_ram_i;
        DevGpio: rsp = tl_gpio_i;
        default: begin
          rsp.d_valid  = err_valid_q;
          rsp.d_opcode = err_opcode_q;
          rsp.d_error  = 1'b1;
        end
      endcase
    end
  end

  assign d_xfer = rsp.d_valid && tl_h_i.d_ready;

  always_comb begin
    tl_h_o         = rsp;
    tl_h_o.a_ready = host_ready;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= StIdle;
      err_valid_q <= 1'b0;
    end else begin
      if (a_xfer) begin
        state_q <= StWaitRsp;
      end else if (d_xfer) begin
        state_q <= StIdle;
      end
      // error response is held here until the host takes it
      if (a_xfer && (dev_sel == DevNone)) begin
        err_valid_q <= 1'b1;
      end else if (d_xfer) begin
        err_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_xfer) begin
      dev_q        <= dev_sel;
      err_opcode_q <= (tl_h_i.a_opcode == Get) ? AccessAckData : AccessAck;
    end
  end

  // host may only see a_ready return after the pending response went out
  a_ready_after_rsp_a: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(host_ready) |-> $past(d_xfer));

  // no device answers unless the crossbar waits for it
  dev_rsp_in_wait_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (tl_ram_i.d_valid || tl_gpio_i.d_valid) |-> (state_q == StWaitRsp));

endmodule

// ==== hw/sram/ram_1p.sv ====
// Single-port word memory with per-bit write mask.
// Read data and rvalid_o come one cycle after a read request.

`include "soc_cfg.svh"

module ram_1p #(
  parameter int Depth = 256
) (
  input  logic                     clk_i,
  input  logic                     req_i,
  input  logic                     write_i,
  input  logic [$clog2(Depth)-1:0] addr_i,
  input  logic [`SOC_DW-1:0]       wdata_i,
  input  logic [`SOC_DW-1:0]       wmask_i,
  output logic                     rvalid_o,
  output logic [`SOC_DW-1:0]       rdata_o
);

  logic [`SOC_DW-1:0] mem [Depth];

  always_ff @(posedge clk_i) begin
    if (req_i && write_i) begin
      // only masked bits change
      mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
    end
  end

  always_ff @(posedge clk_i) begin
    rvalid_o <= req_i && !write_i;
    if (req_i && !write_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

// ==== hw/sram/tlul_adapter_sram.sv ====
// Bus to SRAM adapter: turns one request into memory strobes and returns
// the response two cycles after acceptance, held until the host takes it.

`include "soc_cfg.svh"

module tlul_adapter_sram import tlul_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  tl_h2d_t                tl_i,
  output tl_d2h_t                tl_o,
  output logic                   req_o,
  output logic                   we_o,
  output logic [`SOC_RAM_AW-1:0] addr_o,
  output logic [`SOC_DW-1:0]     wdata_o,
  output logic [`SOC_DW-1:0]     wmask_o,
  input  logic [`SOC_DW-1:0]     rdata_i,
  input  logic                   rvalid_i
);

  logic                   a_xfer;
  logic [(`SOC_DW/8)-1:0] byte_en;
  logic                   pend_q;
  tl_opcode_e             pend_op_q;
  logic                   rsp_valid_q;
  tl_opcode_e             rsp_op_q;
  logic [`SOC_DW-1:0]     rsp_data_q;

  // busy while a request sits in the memory or a response waits
  assign tl_o.a_ready = !pend_q && !rsp_valid_q;
  assign a_xfer       = tl_i.a_valid && tl_o.a_ready;

  assign req_o   = a_xfer;
  assign we_o    = (tl_i.a_opcode != Get);
  assign addr_o  = tl_i.a_address[`SOC_RAM_AW+1:2];
  assign wdata_o = tl_i.a_data;

  // full writes ignore a_mask
  assign byte_en = (tl_i.a_opcode == PutFullData) ? '1 : tl_i.a_mask;

  always_comb begin
    for (int i = 0; i < `SOC_DW / 8; i++) begin
      wmask_o[8*i +: 8] = {8{byte_en[i]}};
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      pend_q <= a_xfer;
      if (pend_q) begin
        rsp_valid_q <= 1'b1;
      end else if (tl_i.d_ready) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_xfer) begin
      pend_op_q <= tl_i.a_opcode;
    end
    // memory answers in the cycle after req
    if (pend_q) begin
      rsp_op_q   <= (pend_op_q == Get) ? AccessAckData : AccessAck;
      rsp_data_q <= rvalid_i ? rdata_i : '0;
    end
  end

  assign tl_o.d_valid  = rsp_valid_q;
  assign tl_o.d_opcode = rsp_op_q;
  assign tl_o.d_data   = rsp_data_q;
  assign tl_o.d_error  = 1'b0;

  // read data only comes back for a read strobe
  rvalid_after_read_a: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_i |-> $past(req_o && !we_o));

endmodule

// ==== hw/gpio/gpio.sv ====
// GPIO block with output, output enable, synchronized inputs and
// rising edge interrupts. Answers each bus request one cycle later.

`include "soc_cfg.svh"

module gpio import tlul_pkg::*, soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  tl_h2d_t                tl_i,
  output tl_d2h_t                tl_o,
  input  logic [`SOC_GPIO_W-1:0] gpio_i,
  output logic [`SOC_GPIO_W-1:0] gpio_o,
  output logic [`SOC_GPIO_W-1:0] gpio_en_o,
  output logic                   intr_o
);

  logic                   a_xfer;
  logic                   is_read;
  logic                   reg_hit;
  logic [2:0]             reg_idx;
  logic                   wr_en;
  logic                   wr_err;
  logic [`SOC_GPIO_W-1:0] rd_val;
  logic [`SOC_GPIO_W-1:0] w1c;
  logic [`SOC_GPIO_W-1:0] rise;
  logic [`SOC_GPIO_W-1:0] out_q, oe_q;
  logic [`SOC_GPIO_W-1:0] sync1_q, sync2_q, prev_q;
  logic [`SOC_GPIO_W-1:0] state_q, enable_q;
  logic                   rsp_valid_q;
  tl_opcode_e             rsp_op_q;
  logic [`SOC_DW-1:0]     rsp_data_q;
  logic                   rsp_err_q;

  assign tl_o.a_ready = !rsp_valid_q;
  assign a_xfer       = tl_i.a_valid && tl_o.a_ready;
  assign is_read      = (tl_i.a_opcode == Get);

  // registers live in the first 32 bytes of the window
  assign reg_hit = (tl_i.a_address[7:5] == 3'b000);
  assign reg_idx = tl_i.a_address[4:2];
  assign wr_en   = a_xfer && !is_read && reg_hit && tl_i.a_mask[0];
  assign wr_err  = !is_read && reg_hit && (reg_idx == RegIn);

  always_comb begin
    rd_val = '0;
    if (reg_hit) begin
      case (reg_idx)
        RegOut:        rd_val = out_q;
        RegOe:         rd_val = oe_q;
        RegIn:         rd_val = sync2_q;
        RegIntrState:  rd_val = state_q;
        RegIntrEnable: rd_val = enable_q;
        default:       rd_val = '0;
      endcase
    end
  end

  assign w1c  = (wr_en && (reg_idx == RegIntrState)) ? tl_i.a_data[`SOC_GPIO_W-1:0] : '0;
  assign rise = sync2_q & ~prev_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_q    <= '0;
      oe_q     <= '0;
      enable_q <= '0;
      state_q  <= '0;
      sync1_q  <= '0;
      sync2_q  <= '0;
      prev_q   <= '0;
    end else begin
      // two flop input sync, then edge detect
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr_en && (reg_idx == RegOut)) begin
        out_q <= tl_i.a_data[`SOC_GPIO_W-1:0];
      end
      if (wr_en && (reg_idx == RegOe)) begin
        oe_q <= tl_i.a_data[`SOC_GPIO_W-1:0];
      end
      if (wr_en && (reg_idx == RegIntrEnable)) begin
        enable_q <= tl_i.a_data[`SOC_GPIO_W-1:0];
      end
      // a new edge wins over a clear in the same cycle
      state_q <= (state_q & ~w1c) | rise;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else if (a_xfer) begin
      rsp_valid_q <= 1'b1;
    end else if (tl_i.d_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_xfer) begin
      rsp_op_q   <= is_read ? AccessAckData : AccessAck;
      rsp_data_q <= is_read ? {{(`SOC_DW-`SOC_GPIO_W){1'b0}}, rd_val} : '0;
      rsp_err_q  <= wr_err;
    end
  end

  assign tl_o.d_valid  = rsp_valid_q;
  assign tl_o.d_opcode = rsp_op_q;
  assign tl_o.d_data   = rsp_data_q;
  assign tl_o.d_error  = rsp_err_q;

  assign gpio_o    = out_q;
  assign gpio_en_o = oe_q;
  assign intr_o    = |(state_q & enable_q);

endmodule

// ==== hw/top_mini.sv ====
// Reduced SoC top: host bus port, main crossbar, SRAM and GPIO.
// The GPIO interrupt leaves as irq_o.

`include "soc_cfg.svh"

module top_mini import tlul_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  tl_h2d_t                tl_i,
  output tl_d2h_t                tl_o,
  input  logic [`SOC_GPIO_W-1:0] gpio_i,
  output logic [`SOC_GPIO_W-1:0] gpio_o,
  output logic [`SOC_GPIO_W-1:0] gpio_en_o,
  output logic                   irq_o
);

  tl_h2d_t tl_ram_h2d;
  tl_d2h_t tl_ram_d2h;
  tl_h2d_t tl_gpio_h2d;
  tl_d2h_t tl_gpio_d2h;

  // sram strobes
  logic                   ram_req;
  logic                   ram_we;
  logic [`SOC_RAM_AW-1:0] ram_addr;
  logic [`SOC_DW-1:0]     ram_wdata;
  logic [`SOC_DW-1:0]     ram_wmask;
  logic [`SOC_DW-1:0]     ram_rdata;
  logic                   ram_rvalid;

  xbar_main u_xbar_main (
    .clk_i,
    .rst_i,
    .tl_h_i    (tl_i),
    .tl_h_o    (tl_o),
    .tl_ram_o  (tl_ram_h2d),
    .tl_ram_i  (tl_ram_d2h),
    .tl_gpio_o (tl_gpio_h2d),
    .tl_gpio_i (tl_gpio_d2h)
  );

  tlul_adapter_sram u_adapter_ram (
    .clk_i,
    .rst_i,
    .tl_i     (tl_ram_h2d),
    .tl_o     (tl_ram_d2h),
    .req_o    (ram_req),
    .we_o     (ram_we),
    .addr_o   (ram_addr),
    .wdata_o  (ram_wdata),
    .wmask_o  (ram_wmask),
    .rdata_i  (ram_rdata),
    .rvalid_i (ram_rvalid)
  );

  ram_1p #(
    .Depth(1 << `SOC_RAM_AW)
  ) u_ram (
    .clk_i,
    .req_i    (ram_req),
    .write_i  (ram_we),
    .addr_i   (ram_addr),
    .wdata_i  (ram_wdata),
    .wmask_i  (ram_wmask),
    .rvalid_o (ram_rvalid),
    .rdata_o  (ram_rdata)
  );

  gpio u_gpio (
    .clk_i,
    .rst_i,
    .tl_i      (tl_gpio_h2d),
    .tl_o      (tl_gpio_d2h),
    .gpio_i,
    .gpio_o,
    .gpio_en_o,
    .intr_o    (irq_o)
  );

endmodule

// ==== dv/tb_top_mini.sv ====
// Testbench for top_mini. Reads bus cases from dv/top_mini_cases.txt, drives the host
// port and the GPIO pins, and checks responses, pins and irq_o against the case file.

`include "soc_cfg.svh"

module tb_top_mini import tlul_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  // one line of the case file
  typedef struct packed {
    logic [8*24-1:0]        name;
    tl_opcode_e             opcode;
    logic [`SOC_AW-1:0]     addr;
    logic [3:0]             mask;
    logic [`SOC_DW-1:0]     wdata;
    logic [`SOC_GPIO_W-1:0] pins;
    logic [`SOC_DW-1:0]     exp_rdata;
    logic                   exp_err;
    logic                   exp_irq;
    logic [`SOC_GPIO_W-1:0] exp_gpio;
  } case_t;

  logic                   clk_i;
  logic                   rst_i;
  tl_h2d_t                tl_i;
  tl_d2h_t                tl_o;
  logic [`SOC_GPIO_W-1:0] gpio_i;
  logic [`SOC_GPIO_W-1:0] gpio_o;
  logic [`SOC_GPIO_W-1:0] gpio_en_o;
  logic                   irq_o;

  case_t                  cases[$];
  logic [`SOC_DW-1:0]     ram_model [int];
  logic [`SOC_GPIO_W-1:0] exp_oe;
  bit                     cases_loaded;

  top_mini i_dut (
    .clk_i,
    .rst_i,
    .tl_i,
    .tl_o,
    .gpio_i,
    .gpio_o,
    .gpio_en_o,
    .irq_o
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  task automatic check_value(input logic [8*24-1:0] name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch %0s %0s: expected %h actual %h", name, what, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "stopped at the first error");
    end
  endtask

  task automatic load_cases();
    int              fd;
    int              code;
    bit              done;
    logic [8*24-1:0] tok;
    logic [8*8-1:0]  op;
    logic [8*256-1:0] rest;
    logic [31:0]     addr, mask, wdata, pins, rdata, err, irq, gout;
    case_t           c;
    fd = $fopen("dv/top_mini_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open the case file dv/top_mini_cases.txt");
      $display("*** FAILED ***");
      $fatal(1, "no stimulus");
    end else begin
      done = 1'b0;
      while (!done) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) begin
          done = 1'b1;
        end else if (tok == 192'("#")) begin
          // skip the column description line
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h",
                         op, addr, mask, wdata, pins, rdata, err, irq, gout);
          if (code != 9 || !(op == 64'("get") || op == 64'("put") || op == 64'("putp"))) begin
            $display("case file line %0s is malformed", tok);
            $display("*** FAILED ***");
            $fatal(1, "bad case file");
          end else begin
            c.name      = tok;
            c.opcode    = (op == 64'("get")) ? Get :
                          (op == 64'("put")) ? PutFullData : PutPartialData;
            c.addr      = addr;
            c.mask      = mask[3:0];
            c.wdata     = wdata;
            c.pins      = pins[`SOC_GPIO_W-1:0];
            c.exp_rdata = rdata;
            c.exp_err   = err[0];
            c.exp_irq   = irq[0];
            c.exp_gpio  = gout[`SOC_GPIO_W-1:0];
            cases.push_back(c);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_reset_state();
    #1;
    check_value(192'("reset"), "a_ready", 32'd1, 32'(tl_o.a_ready));
    check_value(192'("reset"), "d_valid", 32'd0, 32'(tl_o.d_valid));
    check_value(192'("reset"), "gpio_o", 32'd0, 32'(gpio_o));
    check_value(192'("reset"), "gpio_en_o", 32'd0, 32'(gpio_en_o));
    check_value(192'("reset"), "irq_o", 32'd0, 32'(irq_o));
  endtask

  task automatic run_case(input case_t c);
    int                 stall;
    int                 word;
    logic               in_ram;
    logic [3:0]         bytes;
    logic [`SOC_DW-1:0] bits;
    logic [`SOC_DW-1:0] old;
    tl_opcode_e         rsp_op;
    tl_d2h_t            held;
    in_ram = ((c.addr & ~`SOC_RAM_MASK) == `SOC_RAM_BASE);
    word   = int'(c.addr[`SOC_RAM_AW+1:2]);
    rsp_op = (c.opcode == Get) ? AccessAckData : AccessAck;
    // sync plus edge flops need three cycles after a pin change
    @(negedge clk_i);
    gpio_i = c.pins;
    repeat (4 + $urandom_range(0, 3)) @(negedge clk_i);
    tl_i.a_valid   = 1'b1;
    tl_i.a_opcode  = c.opcode;
    tl_i.a_address = c.addr;
    tl_i.a_mask    = c.mask;
    tl_i.a_data    = c.wdata;
    tl_i.d_ready   = 1'b0;
    #1;
    while (!tl_o.a_ready) begin
      @(negedge clk_i);
      #1;
    end
    // taken at the rising edge in between
    @(negedge clk_i);
    tl_i.a_valid = 1'b0;
    #1;
    while (!tl_o.d_valid) begin
      check_value(c.name, "a_ready while busy", 32'd0, 32'(tl_o.a_ready));
      @(negedge clk_i);
      #1;
    end
    held  = tl_o;
    stall = $urandom_range(1, 4);
    repeat (stall) begin
      @(negedge clk_i);
      #1;
      check_value(c.name, "d_valid in stall", 32'd1, 32'(tl_o.d_valid));
      check_value(c.name, "d_data in stall", held.d_data, tl_o.d_data);
      check_value(c.name, "d_error in stall", 32'(held.d_error), 32'(tl_o.d_error));
      check_value(c.name, "a_ready in stall", 32'd0, 32'(tl_o.a_ready));
    end
    @(negedge clk_i);
    tl_i.d_ready = 1'b1;
    #1;
    check_value(c.name, "d_valid", 32'd1, 32'(tl_o.d_valid));
    check_value(c.name, "d_opcode", 32'(rsp_op), 32'(tl_o.d_opcode));
    check_value(c.name, "d_error", 32'(c.exp_err), 32'(tl_o.d_error));
    check_value(c.name, "d_data", c.exp_rdata, tl_o.d_data);
    if (c.opcode == Get && in_ram && ram_model.exists(word)) begin
      check_value(c.name, "d_data vs ram model", ram_model[word], tl_o.d_data);
    end
    // byte merge into the reference memory
    if (c.opcode != Get && in_ram) begin
      bytes = (c.opcode == PutFullData) ? 4'hf : c.mask;
      for (int i = 0; i < 4; i++) begin
        bits[8*i +: 8] = {8{bytes[i]}};
      end
      old = ram_model.exists(word) ? ram_model[word] : '0;
      ram_model[word] = (old & ~bits) | (c.wdata & bits);
    end
    if (c.opcode != Get && c.addr == (`SOC_GPIO_BASE + 32'h4) && !c.exp_err) begin
      exp_oe = c.wdata[`SOC_GPIO_W-1:0];
    end
    @(negedge clk_i);
    tl_i.d_ready = 1'b0;
    #1;
    check_value(c.name, "d_valid after release", 32'd0, 32'(tl_o.d_valid));
    check_value(c.name, "a_ready after release", 32'd1, 32'(tl_o.a_ready));
    check_value(c.name, "irq_o", 32'(c.exp_irq), 32'(irq_o));
    check_value(c.name, "gpio_o", 32'(c.exp_gpio), 32'(gpio_o));
    check_value(c.name, "gpio_en_o", 32'(exp_oe), 32'(gpio_en_o));
  endtask

  // bus hang guard sized from the number of cases
  initial begin
    wait (cases_loaded);
    repeat (cases.size() * 200 + 8) @(posedge clk_i);
    $display("timeout: the bus hung, the cases did not finish in time");
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(32'h733c_6435));
    exp_oe       = '0;
    cases_loaded = 1'b0;
    rst_i        = 1'b1;
    tl_i         = '0;
    gpio_i       = '0;
    load_cases();
    cases_loaded = 1'b1;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    check_reset_state();
    foreach (cases[i]) begin
      run_case(cases[i]);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== dv/top_mini_cases.txt ====
# name op addr mask wdata gpio_i exp_rdata exp_err exp_irq exp_gpio_o
# op is get, put or putp; numbers are hex, addresses are byte addresses
ram_wr_full      put  00000010 f deadbeef 00 00000000 0 0 00
ram_rd_full      get  00000010 f 00000000 00 deadbeef 0 0 00
ram_wr_base      put  00000020 f 11223344 00 00000000 0 0 00
ram_wr_part      putp 00000020 5 aabbccdd 00 00000000 0 0 00
ram_rd_part      get  00000020 f 00000000 00 11bb33dd 0 0 00
unmapped_wr      put  20000000 f 12345678 00 00000000 1 0 00
unmapped_rd      get  00000400 f 00000000 00 00000000 1 0 00
ram_rd_after_err get  00000010 f 00000000 00 deadbeef 0 0 00
gpio_out_wr      put  10000000 f 000000a5 00 00000000 0 0 a5
gpio_oe_wr       put  10000004 f 0000000f 00 00000000 0 0 a5
gpio_out_rd      get  10000000 f 00000000 00 000000a5 0 0 a5
gpio_oe_rd       get  10000004 f 00000000 00 0000000f 0 0 a5
unmapped_gpio    put  10000100 f 000000ff 00 00000000 1 0 a5
gpio_out_rd2     get  10000000 f 00000000 00 000000a5 0 0 a5
gpio_in_rd       get  10000008 f 00000000 3c 0000003c 0 0 a5
intr_state_rd    get  1000000c f 00000000 3c 0000003c 0 0 a5
intr_en_wr       put  10000010 f 00000001 3c 00000000 0 0 a5
pin0_rise        get  1000000c f 00000000 3d 0000003d 0 1 a5
intr_clr         put  1000000c f 00000001 3d 00000000 0 0 a5
intr_state_rd2   get  1000000c f 00000000 3d 0000003c 0 0 a5
pin7_rise        get  1000000c f 00000000 bd 000000bc 0 0 a5
in_wr_err        put  10000008 f 000000ff bd 00000000 1 0 a5
ram_rd_last      get  00000020 f 00000000 bd 11bb33dd 0 0 a5

// ==== compile.f ====
+incdir+common
common/tlul_pkg.sv
common/soc_pkg.sv
hw/xbar/xbar_main.sv
hw/sram/ram_1p.sv
hw/sram/tlul_adapter_sram.sv
hw/gpio/gpio.sv
hw/top_mini.sv
dv/tb_top_mini.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the top_mini testbench with Verilator from the project root.
# The result is decided by searching sim.log for the fail line.

verilator --binary --timing --assert -f compile.f --top-module tb_top_mini -Mdir obj_dir \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_top_mini > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log

cat sim.log

grep -q -e '\*\*\* FAILED \*\*\*' -e 'simulator exited with an error' sim.log \
  && { echo "simulation failed"; exit 1; } || { echo "simulation done"; exit 0; }
